/* run.sh */
#!/bin/sh
# builds the fetch front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fetchTb -f tb.f --Mdir obj_dir -o fetchSim

./obj_dir/fetchSim 2>&1 | tee sim.log

# a missing pass line makes grep and the script fail
grep -qx "TEST PASSED" sim.log

/* src/fetchPkg.sv */
`default_nettype none

package fetchPkg;

	// widths that carry a meaning
	typedef logic [19:0] pcAddr;		// byte address of an instruction
	typedef logic [16:0] granAddr;		// 8-byte granule, pc bits 19:3
	typedef logic [127:0] lineData;		// two granules, eight words
	typedef logic [15:0] instrWord;		// one 16-bit instruction
	typedef logic [2:0] wordIdx;		// word position inside a line
	typedef logic [1:0] memOk;			// response status from the tile port
	typedef logic [4:0] memOpm;			// request code to the tile port

	// response status codes
	localparam memOk MemOkReady = 2'h0;	// port idle
	localparam memOk MemOkOk = 2'h1;	// line valid this cycle
	localparam memOk MemOkHold = 2'h2;	// busy, keep waiting

	// request codes
	localparam memOpm OpmReady = 5'h00;	// no request
	localparam memOpm OpmRdTile = 5'h0F;	// read one 16-byte line

	// fetch address handling
	localparam pcAddr ResetPc = '0;		// first fetch after reset
	localparam pcAddr PcStep = 20'd2;	// one instruction word
	localparam int GranLsb = 3;			// granule offset bits in a pc

	// fetch queue geometry
	localparam int QueueDepth = 4;
	localparam int QueuePtrW = 2;		// log2 of QueueDepth

	typedef logic [QueuePtrW-1:0] queuePtr;
	typedef logic [QueuePtrW:0] queueCount;	// one extra bit to tell full from empty

	// line request toward the tile memory
	typedef struct packed
	{
		pcAddr addr;	// granule followed by three zero bits
		memOpm opm;
	} memReq;

	// line response from the tile memory
	typedef struct packed
	{
		lineData data;	// word k in bits 16k+15:16k
		memOk ok;
	} memResp;

	// one fetched instruction with its address, 36 bits
	typedef struct packed
	{
		pcAddr pc;
		instrWord word;
	} fetchEntry;

endpackage

`default_nettype wire

/* src/fetchQueue.sv */
`default_nettype none

module fetchQueue
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic flush,					// empties the queue at the next edge
	input wire logic push,
	input wire fetchPkg::fetchEntry pushEntry,
	input wire logic take,					// pop strobe
	output logic full,
	output logic outValid,
	output fetchPkg::fetchEntry outEntry
);

	fetchPkg::fetchEntry slots [fetchPkg::QueueDepth];	// entry storage
	fetchPkg::queuePtr rdPtr;	// head slot
	fetchPkg::queuePtr wrPtr;	// next free slot
	fetchPkg::queueCount count;	// entries held

	logic doPush;
	logic doTake;

	// status and head are read straight from the registers
	always_comb
	begin
		full = (count == fetchPkg::queueCount'(fetchPkg::QueueDepth));
		outValid = (count != '0);
		outEntry = slots[rdPtr];
	end

	// a flush drops any push or take of the same cycle
	always_comb
	begin
		doPush = push && !full && !flush;
		doTake = take && outValid && !flush;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			// pointers wrap naturally, depth is a power of two
			if (doPush)
			begin
				wrPtr <= fetchPkg::queuePtr'(wrPtr + 1'b1);
			end
			if (doTake)
			begin
				rdPtr <= fetchPkg::queuePtr'(rdPtr + 1'b1);
			end

			case ({doPush, doTake})
				2'b10: count <= fetchPkg::queueCount'(count + 1'b1);
				2'b01: count <= fetchPkg::queueCount'(count - 1'b1);
				default: count <= count;	// idle, or push and take together
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (doPush)
		begin
			slots[wrPtr] <= pushEntry;
		end
	end

endmodule

`default_nettype wire

/* src/fetchTop.sv */
`default_nettype none

module fetchTop
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic redirect,				// one-cycle strobe
	input wire fetchPkg::pcAddr redirectPc,
	input wire logic take,					// pop the queue head
	output fetchPkg::memReq req,			// line request to tile memory
	input wire fetchPkg::memResp resp,		// line response
	output logic outValid,
	output fetchPkg::fetchEntry outEntry
);

	fetchPkg::pcAddr fetchPc;		// current fetch address
	fetchPkg::instrWord word;		// word at fetchPc when wordOk
	logic wordOk;
	logic full;
	logic push;
	logic flush;
	fetchPkg::fetchEntry pushEntry;

	// accept only when the word is there, the queue has room and no redirect
	always_comb
	begin
		push = wordOk && !full && !redirect;
		flush = redirect;
		pushEntry.pc = fetchPc;
		pushEntry.word = word;
	end

	pcSequencer pcSequencer_inst
	(
		.clock(clock),
		.arstN(arstN),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.wordOk(wordOk),
		.full(full),
		.fetchPc(fetchPc)
	);

	icTile icTile_inst
	(
		.clock(clock),
		.arstN(arstN),
		.fetchPc(fetchPc),
		.word(word),
		.wordOk(wordOk),
		.req(req),
		.resp(resp)
	);

	fetchQueue fetchQueue_inst
	(
		.clock(clock),
		.arstN(arstN),
		.flush(flush),
		.push(push),
		.pushEntry(pushEntry),
		.take(take),
		.full(full),
		.outValid(outValid),
		.outEntry(outEntry)
	);

endmodule

`default_nettype wire

/* src/icTile.sv */
`default_nettype none

module icTile
(
	input wire logic clock,
	input wire logic arstN,
	input wire fetchPkg::pcAddr fetchPc,
	output fetchPkg::instrWord word,
	output logic wordOk,
	output fetchPkg::memReq req,
	input wire fetchPkg::memResp resp
);

	// cached line
	fetchPkg::lineData lineBuf;		// payload, valid only with lineReady
	fetchPkg::granAddr lineGran;	// granule of the low half
	logic lineReady;

	// outstanding line request
	fetchPkg::memReq reqReg;

	// lookup terms
	fetchPkg::granAddr pcGran;		// granule the pc falls in
	fetchPkg::granAddr nextGran;	// granule of the high half
	logic inLow;
	logic inHigh;
	logic hit;
	fetchPkg::wordIdx wordSel;

	// request tracking
	logic reqBusy;
	logic lineArrives;
	logic startReq;

	always_comb
	begin
		pcGran = fetchPc[$bits(fetchPkg::pcAddr)-1:fetchPkg::GranLsb];
		nextGran = fetchPkg::granAddr'(lineGran + 1'b1);
		inLow = (pcGran == lineGran);
		inHigh = (pcGran == nextGran);
		hit = lineReady && (inLow || inHigh);

		// high half of the line when the pc is not in the low granule
		wordSel = {!inLow, fetchPc[2:1]};
	end

	// word select is purely combinational
	always_comb
	begin
		word = lineBuf[wordSel * $bits(fetchPkg::instrWord) +: $bits(fetchPkg::instrWord)];
		wordOk = hit;
	end

	always_comb
	begin
		reqBusy = (reqReg.opm == fetchPkg::OpmRdTile);
		lineArrives = reqBusy && (resp.ok == fetchPkg::MemOkOk);

		// a miss in either half reloads starting at the pc's own granule,
		// so the line then covers this granule and the one after it
		startReq = !reqBusy && !hit;
	end

	// request and ready bit
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			lineReady <= 1'b0;
			reqReg.addr <= '0;
			reqReg.opm <= fetchPkg::OpmReady;
		end
		else if (lineArrives)
		begin
			lineReady <= 1'b1;	// hit available next cycle
			reqReg.opm <= fetchPkg::OpmReady;
		end
		else if (startReq)
		begin
			lineReady <= 1'b0;
			reqReg.addr <= {pcGran, 3'b000};
			reqReg.opm <= fetchPkg::OpmRdTile;
		end
	end

	// line payload and its granule
	always_ff @(posedge clock)
	begin
		if (lineArrives)
		begin
			lineBuf <= resp.data;
			// granule from the held request, the pc may have moved meanwhile
			lineGran <= reqReg.addr[$bits(fetchPkg::pcAddr)-1:fetchPkg::GranLsb];
		end
	end

	assign req = reqReg;	// address held stable until the ok pulse

endmodule

`default_nettype wire

/* src/pcSequencer.sv */
`default_nettype none

module pcSequencer
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic redirect,				// one-cycle strobe
	input wire fetchPkg::pcAddr redirectPc,
	input wire logic wordOk,				// tile has the word at fetchPc
	input wire logic full,					// queue cannot take another entry
	output fetchPkg::pcAddr fetchPc
);

	logic accept;				// word goes into the queue this cycle
	fetchPkg::pcAddr stepPc;	// address of the following word
	fetchPkg::pcAddr nextPc;

	// the tile answers combinationally, so an accept is
	// decided in the same cycle the pc is presented
	always_comb
	begin
		accept = wordOk && !full;
		stepPc = fetchPc + fetchPkg::PcStep;
	end

	always_comb
	begin
		nextPc = fetchPc;	// hold on miss or back-pressure
		if (redirect)
		begin
			nextPc = redirectPc;	// redirect wins over a pending accept
		end
		else if (accept)
		begin
			nextPc = stepPc;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			fetchPc <= fetchPkg::ResetPc;
		end
		else
		begin
			fetchPc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
src/fetchPkg.sv
src/pcSequencer.sv
src/icTile.sv
src/fetchQueue.sv
src/fetchTop.sv
tb/tileMemModel.sv
tb/fetchTop_properties.sv
tb/fetchTb.sv

/* tb/fetchTb.sv */
`default_nettype none

module fetchTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] WordPattern = 16'h5A3C;	// mask on memory words
	localparam int WaitLimit = 60;		// cycles allowed for outValid to rise
	localparam int StreamTakes = 600;	// takes before redirects start
	localparam int TakeTotal = 2000;

	logic clock;
	logic arstN;
	logic redirect;
	fetchPkg::pcAddr redirectPc;
	logic take;
	fetchPkg::memReq req;
	fetchPkg::memResp resp;
	logic outValid;
	fetchPkg::fetchEntry outEntry;

	fetchPkg::pcAddr expPc;		// pc of the next entry to be taken
	int takeCount;
	int pick;

	fetchTop fetchTop_inst (.*);

	tileMemModel #(.WordPattern(WordPattern)) tileMemModel_inst (.*);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// waits for the head, checks it against the model, then pops it
	task automatic popEntry();
		int waitCount;
		waitCount = 0;
		while (!outValid)
		begin
			assert (waitCount < WaitLimit)
				else abortRun("timeout: outValid did not rise while waiting for an entry");
			@(negedge clock);
			waitCount++;
		end
		assert (outEntry.pc == expPc)
			else abortRun($sformatf("[FAIL] %0d ns outEntry.pc: got %h, expected %h",
				$time, outEntry.pc, expPc));
		assert (outEntry.word == (expPc[15:0] ^ WordPattern))
			else abortRun($sformatf("[FAIL] %0d ns outEntry.word: got %h, expected %h",
				$time, outEntry.word, expPc[15:0] ^ WordPattern));
		take = 1'b1;
		@(negedge clock);
		take = 1'b0;
		expPc = expPc + 20'd2;
		takeCount++;
	endtask

	task automatic redirectTo(input fetchPkg::pcAddr target);
		redirect = 1'b1;
		redirectPc = target;
		@(negedge clock);
		redirect = 1'b0;
		expPc = target;
		assert (!outValid)	// old entries gone
			else abortRun($sformatf("[FAIL] %0d ns outValid: got %b, expected %b",
				$time, outValid, 1'b0));
	endtask

	// no takes, so the queue fills and must then stay valid
	task automatic holdOff(input int cycles);
		logic seenValid;
		seenValid = 1'b0;
		repeat (cycles)
		begin
			@(negedge clock);
			assert (!seenValid || outValid)
				else abortRun($sformatf("[FAIL] %0d ns outValid: got %b, expected %b",
					$time, outValid, 1'b1));
			seenValid = seenValid || outValid;
		end
	endtask

	function automatic fetchPkg::pcAddr randomPc();
		logic [31:0] r;
		fetchPkg::pcAddr pc;
		r = $urandom;
		pc = r[19:0];
		pc[0] = 1'b0;			// halfword aligned
		pc[3] = pc[3] | r[31];	// more odd granules
		return pc;
	endfunction

	initial
	begin
		void'($urandom(32'h9740));
		arstN = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		take = 1'b0;
		expPc = fetchPkg::ResetPc;
		takeCount = 0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		assert (!outValid)
			else abortRun($sformatf("[FAIL] %0d ns outValid: got %b, expected %b",
				$time, outValid, 1'b0));
		assert (req.opm == fetchPkg::OpmReady)
			else abortRun($sformatf("[FAIL] %0d ns req.opm: got %h, expected %h",
				$time, req.opm, fetchPkg::OpmReady));
		// plain stream across granule and line boundaries
		while (takeCount < StreamTakes)
		begin
			repeat ($urandom_range(2, 0)) @(negedge clock);
			popEntry();
		end
		while (takeCount < TakeTotal)
		begin
			pick = $urandom_range(99, 0);
			if (pick < 4)
				redirectTo(randomPc());
			else if (pick < 7)
				holdOff(12);
			else
			begin
				repeat ($urandom_range(1, 0)) @(negedge clock);
				popEntry();
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/fetchTop_properties.sv */
`default_nettype none

module fetchTop_properties
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic redirect,
	input wire fetchPkg::memReq req,
	input wire fetchPkg::memResp resp,
	input wire logic outValid
);
	timeunit 1ns;
	timeprecision 100ps;

	lineAligned: assert property (@(posedge clock) disable iff (!arstN)
		req.opm == fetchPkg::OpmRdTile |-> req.addr[2:0] == 3'b000)
		else $error("line request address is not granule aligned");

	// request must not move while the memory is still working on it
	addrHeld: assert property (@(posedge clock) disable iff (!arstN)
		(req.opm == fetchPkg::OpmRdTile && resp.ok != fetchPkg::MemOkOk) |=> $stable(req.addr))
		else $error("line request address changed before the ok pulse");

	noValidAfterRedirect: assert property (@(posedge clock) disable iff (!arstN)
		redirect |=> !outValid)	// flushed queue stays empty one cycle
		else $error("outValid high in the cycle after a redirect");

endmodule

bind fetchTop fetchTop_properties fetchTop_properties_inst
(
	.clock(clock),
	.arstN(arstN),
	.redirect(redirect),
	.req(req),
	.resp(resp),
	.outValid(outValid)
);

`default_nettype wire

/* tb/tileMemModel.sv */
`default_nettype none

module tileMemModel
#(
	parameter logic [15:0] WordPattern = 16'h0000	// xor mask on every word
)
(
	input wire logic clock,
	input wire logic arstN,
	input wire fetchPkg::memReq req,
	output fetchPkg::memResp resp
);
	timeunit 1ns;
	timeprecision 100ps;

	fetchPkg::pcAddr lineAddr;	// line being served
	logic busy;
	int holdLeft;				// hold cycles still to go

	// word k holds the low half of its own byte address, masked
	function automatic fetchPkg::lineData buildLine(input fetchPkg::pcAddr base);
		fetchPkg::lineData line;
		fetchPkg::pcAddr byteAddr;
		int k;
		for (k = 0; k < 8; k++)
		begin
			byteAddr = base + fetchPkg::pcAddr'(2 * k);
			line[16 * k +: 16] = byteAddr[15:0] ^ WordPattern;
		end
		return line;
	endfunction

	// response changes on the falling edge like every other DUT input
	initial
	begin
		resp.data = '0;
		resp.ok = fetchPkg::MemOkReady;
		lineAddr = '0;
		busy = 1'b0;
		holdLeft = 0;
		forever
		begin
			@(negedge clock);
			if (!arstN)
			begin
				busy = 1'b0;
				resp.ok = fetchPkg::MemOkReady;
			end
			else if (busy && holdLeft > 0)
			begin
				holdLeft--;	// still busy
			end
			else if (busy)
			begin
				resp.data = buildLine(lineAddr);
				resp.ok = fetchPkg::MemOkOk;	// single ok cycle
				busy = 1'b0;
			end
			else if (req.opm == fetchPkg::OpmRdTile)
			begin
				busy = 1'b1;
				lineAddr = req.addr;
				holdLeft = $urandom_range(3, 0);	// 1 to 4 hold cycles in all
				resp.ok = fetchPkg::MemOkHold;
			end
			else
			begin
				resp.ok = fetchPkg::MemOkReady;
			end
		end
	end

endmodule

`default_nettype wire
